// File: hw/udp_pkg.sv
package udp_pkg;

  // bits per beat on the rx bus, 1, 2, 4 or 8.
  localparam int BUS_W = 2;

  localparam int HDR_BEATS  = 64 / BUS_W;  // beats in the 8-byte header.
  localparam int WORD_BEATS = 16 / BUS_W;  // beats per checksum word.

  // counter widths, header count must reach HDR_BEATS itself.
  localparam int HDR_CNT_W  = $clog2(HDR_BEATS + 1);
  localparam int WORD_CNT_W = $clog2(WORD_BEATS);

  localparam logic [15:0] PORT_DHCP_SRV = 16'd67;
  localparam logic [15:0] PORT_DHCP_CLI = 16'd68;
  localparam logic [15:0] PORT_RTSP     = 16'd554;

  localparam logic [15:0] IP_PROTO_UDP = 16'd17;  // pseudo-header protocol word.

  // what the ip layer reports for the current frame.
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] ip_udp_len;
  } udp_ip_info_t;

  // header fields in wire order, first field in the top bits.
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
    logic [15:0] cksum;
  } udp_hdr_t;

  // end of frame checksum result.
  typedef struct packed {
    logic done;
    logic ok;
  } udp_sum_t;

endpackage

// File: hw/udp_header_parse.sv
`timescale 1ns/1ps

module udp_header_parse (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      axiiv,
  input  logic [udp_pkg::BUS_W-1:0] axiid,
  output udp_pkg::udp_hdr_t         hdr,
  output logic                      hdr_done
);

  logic [udp_pkg::HDR_CNT_W-1:0] cnt;
  logic [5:0]                    msb;
  logic                          in_hdr;

  // the count picks the field and the slot within it.
  assign msb    = 6'(63 - udp_pkg::BUS_W * int'(cnt));
  assign in_hdr = (int'(cnt) < udp_pkg::HDR_BEATS);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt      <= '0;
      hdr_done <= 1'b0;
    end else if (axiiv) begin
      if (in_hdr) begin
        cnt <= cnt + 1'b1;
      end
      if (int'(cnt) == udp_pkg::HDR_BEATS - 1) begin
        hdr_done <= 1'b1;  // last header beat.
      end else if (cnt == '0) begin
        hdr_done <= 1'b0;  // new frame.
      end
    end else begin
      cnt <= '0;
    end
  end

  // header bits are captured msb first.
  always_ff @(posedge clk) begin
    if (axiiv && in_hdr) begin
      hdr[msb -: udp_pkg::BUS_W] <= axiid;
    end
  end

  // the header is flagged in the same cycle the count fills.
  a_done_at_full: assert property (
    @(posedge clk) disable iff (rst)
    $rose(hdr_done) |-> int'(cnt) == udp_pkg::HDR_BEATS
  );

  // a previous frame's result must not survive the start of a new one.
  a_done_clears: assert property (
    @(posedge clk) disable iff (rst)
    $rose(axiiv) |=> !hdr_done
  );

endmodule

// File: hw/udp_cksum.sv
`timescale 1ns/1ps

module udp_cksum (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      axiiv,
  input  logic [udp_pkg::BUS_W-1:0] axiid,
  input  udp_pkg::udp_ip_info_t     ip_info,
  output udp_pkg::udp_sum_t         sum
);

  logic [1:0]                     seed_state;
  logic                           seed_new;
  logic [15:0]                    src_f;
  logic [15:0]                    dst_f;
  logic [15:0]                    len_f;
  logic [15:0]                    ip_f;
  logic [15:0]                    seed;
  logic [udp_pkg::WORD_CNT_W-1:0] wcnt;
  logic                           word_last;
  logic [15:0]                    word_sr;
  logic [15:0]                    word_full;
  logic [15:0]                    word_part;
  logic [15:0]                    word_term;
  logic [4:0]                     pad;
  logic [15:0]                    acc;
  logic [15:0]                    acc_next;
  logic                           in_frame;
  logic                           frame_end;

  // ones-complement add with end-around carry.
  function automatic logic [15:0] oc_add(input logic [15:0] a, input logic [15:0] b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + 16'(s[16]);
  endfunction

  // pseudo-header over three beats, keeps each stage to one adder.
  always_ff @(posedge clk) begin
    if (rst) begin
      seed_state <= 2'd0;
      seed_new   <= 1'b0;
    end else begin
      seed_new <= axiiv && (seed_state == 2'd2);
      if (!axiiv) begin
        seed_state <= 2'd0;
      end else if (seed_state != 2'd3) begin
        seed_state <= seed_state + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (axiiv) begin
      case (seed_state)
        2'd0: begin
          src_f <= oc_add(ip_info.src_ip[31:16], ip_info.src_ip[15:0]);
          dst_f <= oc_add(ip_info.dst_ip[31:16], ip_info.dst_ip[15:0]);
          len_f <= oc_add(ip_info.ip_udp_len, udp_pkg::IP_PROTO_UDP);
        end
        2'd1: ip_f <= oc_add(src_f, dst_f);
        2'd2: seed <= oc_add(ip_f, len_f);
        default: ;
      endcase
    end
  end

  assign frame_end = !axiiv && in_frame;
  assign word_last = (int'(wcnt) == udp_pkg::WORD_BEATS - 1);
  assign word_full = {word_sr[15-udp_pkg::BUS_W:0], axiid};

  // odd tail, shift the captured bits up and pad with zeros.
  assign pad       = 5'(16 - udp_pkg::BUS_W * int'(wcnt));
  assign word_part = word_sr << pad;

  assign word_term = axiiv ? (word_last ? word_full : 16'h0000) : word_part;
  assign acc_next  = oc_add(oc_add(acc, word_term), seed_new ? seed : 16'h0000);

  always_ff @(posedge clk) begin
    if (axiiv) begin
      word_sr <= word_full;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame <= 1'b0;
      wcnt     <= '0;
      acc      <= 16'h0000;
      sum      <= '0;
    end else begin
      in_frame <= axiiv;
      sum.done <= frame_end;
      if (frame_end) begin
        sum.ok <= (acc_next == 16'hffff);
      end
      if (axiiv) begin
        wcnt <= word_last ? '0 : wcnt + 1'b1;
        acc  <= acc_next;
      end else begin
        wcnt <= '0;
        acc  <= 16'h0000;
      end
    end
  end

  a_seed_ready: assert property (
    @(posedge clk) disable iff (rst)
    $fell(axiiv) |-> (seed_state == 2'd3)
  );

endmodule

// File: hw/udp_verdict.sv
`timescale 1ns/1ps

module udp_verdict (
  input  logic                  clk,
  input  logic                  rst,
  input  udp_pkg::udp_hdr_t     hdr,
  input  logic                  hdr_done,
  input  udp_pkg::udp_ip_info_t ip_info,
  input  udp_pkg::udp_sum_t     sum,
  output logic                  axiov,
  output logic                  kill
);

  logic port_ok;
  logic len_ok;
  logic cksum_used;
  logic kill_next;

  assign port_ok = (hdr.dst_port == udp_pkg::PORT_DHCP_SRV) ||
                   (hdr.dst_port == udp_pkg::PORT_DHCP_CLI) ||
                   (hdr.dst_port == udp_pkg::PORT_RTSP);

  // header length has to agree with what ip saw.
  assign len_ok = (hdr.length == ip_info.ip_udp_len);

  assign axiov = hdr_done && port_ok && len_ok;

  // zero checksum field means the sender skipped it.
  assign cksum_used = (hdr.cksum != 16'h0000);

  assign kill_next = sum.done && axiov && cksum_used && !sum.ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      kill <= 1'b0;
    end else begin
      kill <= kill_next;  // one cycle pulse.
    end
  end

  // kill never stretches past a single cycle.
  a_kill_one_cycle: assert property (
    @(posedge clk) disable iff (rst)
    kill |=> !kill
  );

endmodule

// File: hw/udp_rx.sv
`timescale 1ns/1ps

module udp_rx (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      axiiv,
  input  logic [udp_pkg::BUS_W-1:0] axiid,
  input  udp_pkg::udp_ip_info_t     ip_info,
  output logic                      axiov,
  output logic                      kill,
  output udp_pkg::udp_hdr_t         hdr
);

  logic              hdr_done;
  udp_pkg::udp_sum_t sum;

  // header parse and checksum run side by side on the same beats.
  udp_header_parse u_parse (
    .clk      (clk),
    .rst      (rst),
    .axiiv    (axiiv),
    .axiid    (axiid),
    .hdr      (hdr),
    .hdr_done (hdr_done)
  );

  udp_cksum u_cksum (
    .clk     (clk),
    .rst     (rst),
    .axiiv   (axiiv),
    .axiid   (axiid),
    .ip_info (ip_info),
    .sum     (sum)
  );

  udp_verdict u_verdict (
    .clk      (clk),
    .rst      (rst),
    .hdr      (hdr),
    .hdr_done (hdr_done),
    .ip_info  (ip_info),
    .sum      (sum),
    .axiov    (axiov),
    .kill     (kill)
  );

endmodule

// File: verif/tb_udp_rx.sv
`timescale 1ns/1ps

module tb_udp_rx;

  localparam int NUM_ROWS    = 10;
  localparam int MAX_BYTES   = 64;
  localparam int GAP_CYCLES  = 4;
  localparam int HDR_TIMEOUT = 4;

  // one frame per row.
  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [7:0]  pay_len;
    logic        len_bad;
    logic        corrupt;
    logic        zero_ck;
  } row_t;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      axiiv;
  logic [udp_pkg::BUS_W-1:0] axiid;
  udp_pkg::udp_ip_info_t     ip_info;
  logic                      axiov;
  logic                      kill;
  udp_pkg::udp_hdr_t         hdr;

  row_t                  rows [0:NUM_ROWS-1];
  logic [7:0]            frame_bytes [0:MAX_BYTES-1];
  int                    frame_len;
  udp_pkg::udp_ip_info_t cur_ip;
  udp_pkg::udp_hdr_t     exp_hdr;
  logic                  exp_axiov;
  logic                  exp_kill;
  integer                seed = 32'h61f3;

  udp_rx u_dut (
    .clk     (clk),
    .rst     (rst),
    .axiiv   (axiiv),
    .axiid   (axiid),
    .ip_info (ip_info),
    .axiov   (axiov),
    .kill    (kill),
    .hdr     (hdr)
  );

  always #50 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic load_table();
    rows[0] = '{32'hc0a8_0101, 32'hc0a8_01ff, 16'd68,   16'd67,  8'd20, 1'b0, 1'b0, 1'b0};
    rows[1] = '{32'h0a00_0002, 32'h0a00_0001, 16'd67,   16'd68,  8'd13, 1'b0, 1'b0, 1'b0};
    rows[2] = '{32'hac10_2003, 32'hac10_20fe, 16'd4321, 16'd554, 8'd7,  1'b0, 1'b0, 1'b0};
    rows[3] = '{32'hc0a8_0a0a, 32'hc0a8_0a01, 16'd5000, 16'd80,  8'd10, 1'b0, 1'b0, 1'b0};
    rows[4] = '{32'hffff_0000, 32'h0000_ffff, 16'd68,   16'd67,  8'd16, 1'b0, 1'b1, 1'b0};
    rows[5] = '{32'h7f00_0001, 32'h7f00_0001, 16'd9000, 16'd554, 8'd9,  1'b0, 1'b1, 1'b0};
    rows[6] = '{32'hc0a8_0102, 32'hc0a8_0103, 16'd67,   16'd68,  8'd12, 1'b0, 1'b1, 1'b1};
    rows[7] = '{32'h0a01_0203, 32'h0a01_0204, 16'd68,   16'd67,  8'd11, 1'b1, 1'b1, 1'b0};
    rows[8] = '{32'h0a01_0205, 32'h0a01_0206, 16'd1234, 16'd80,  8'd5,  1'b0, 1'b1, 1'b0};
    rows[9] = '{32'hdead_beef, 32'hcafe_f00d, 16'd67,   16'd68,  8'd1,  1'b0, 1'b0, 1'b0};
  endtask

  // folded ones-complement sum over pseudo-header and frame and then inverted.
  function automatic logic [15:0] ref_cksum(input udp_pkg::udp_ip_info_t ipi, input int nbytes);
    logic [31:0] acc;
    logic [15:0] w;
    acc = 32'(ipi.src_ip[31:16]) + 32'(ipi.src_ip[15:0]) + 32'(ipi.dst_ip[31:16]) +
          32'(ipi.dst_ip[15:0]) + 32'd17 + 32'(ipi.ip_udp_len);
    for (int i = 0; i < nbytes; i += 2) begin
      w = {frame_bytes[i], (i + 1 < nbytes) ? frame_bytes[i + 1] : 8'h00};  // odd tail padded.
      acc = acc + 32'(w);
    end
    while (acc[31:16] != 16'h0000) begin
      acc = 32'(acc[31:16]) + 32'(acc[15:0]);
    end
    w = ~acc[15:0];
    return (w == 16'h0000) ? 16'hffff : w;
  endfunction

  task automatic build_frame(input row_t r);
    logic [15:0] udp_len;
    logic [15:0] ck;
    logic        port_ok;
    udp_len   = 16'(8 + int'(r.pay_len));
    frame_len = 8 + int'(r.pay_len);
    cur_ip    = '{r.src_ip, r.dst_ip, r.len_bad ? udp_len + 16'd4 : udp_len};
    frame_bytes[0] = r.src_port[15:8];
    frame_bytes[1] = r.src_port[7:0];
    frame_bytes[2] = r.dst_port[15:8];
    frame_bytes[3] = r.dst_port[7:0];
    frame_bytes[4] = udp_len[15:8];
    frame_bytes[5] = udp_len[7:0];
    frame_bytes[6] = 8'h00;
    frame_bytes[7] = 8'h00;
    for (int i = 0; i < int'(r.pay_len); i++) begin
      frame_bytes[8 + i] = 8'($random(seed));
    end
    ck = r.zero_ck ? 16'h0000 : ref_cksum(cur_ip, frame_len);
    frame_bytes[6] = ck[15:8];
    frame_bytes[7] = ck[7:0];
    if (r.corrupt) begin
      frame_bytes[8 + int'(r.pay_len) / 2] ^= 8'h10;  // damage after checksumming.
    end
    port_ok = (r.dst_port == 16'd67) || (r.dst_port == 16'd68) || (r.dst_port == 16'd554);
    exp_hdr   = '{r.src_port, r.dst_port, udp_len, ck};
    exp_axiov = port_ok && !r.len_bad;
    exp_kill  = exp_axiov && (ck != 16'h0000) && r.corrupt;
  endtask

  task automatic wait_hdr_done(input int row);
    int n;
    n = 0;
    while (!u_dut.hdr_done) begin
      if (n == HDR_TIMEOUT) begin
        stop_run($sformatf("row %0d: timed out waiting for the header to be parsed", row));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic send_frame(input int row);
    int         nbeats;
    int         bit_pos;
    logic [7:0] cur;
    nbeats = frame_len * 8 / udp_pkg::BUS_W;
    for (int b = 0; b < nbeats; b++) begin
      next_cycle();
      bit_pos = b * udp_pkg::BUS_W;
      cur     = frame_bytes[bit_pos / 8];
      axiiv   = 1'b1;
      axiid   = cur[7 - (bit_pos % 8) -: udp_pkg::BUS_W];  // msb first.
      ip_info = cur_ip;
      if (b == udp_pkg::HDR_BEATS) begin
        wait_hdr_done(row);
      end
      #1;
      compare(64'(kill), 64'd0, $sformatf("row %0d kill during frame", row));
      if (b == udp_pkg::HDR_BEATS) begin
        compare(64'(hdr), 64'(exp_hdr), $sformatf("row %0d header fields", row));
      end
      if (b == nbeats - 1) begin
        compare(64'(axiov), 64'(exp_axiov), $sformatf("row %0d axiov on last beat", row));
      end
    end
  endtask

  // kill is due in gap cycle 2 when axiiv has been seen low for two edges.
  task automatic end_of_frame(input int row);
    for (int g = 0; g < GAP_CYCLES; g++) begin
      next_cycle();
      axiiv = 1'b0;
      axiid = '0;
      #1;
      compare(64'(kill), (g == 2) ? 64'(exp_kill) : 64'd0,
              $sformatf("row %0d kill in gap cycle %0d", row, g));
    end
  endtask

  initial begin
    rst     = 1'b1;
    axiiv   = 1'b0;
    axiid   = '0;
    ip_info = '0;
    load_table();
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      build_frame(rows[i]);
      send_frame(i);
      end_of_frame(i);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: sources.f
hw/udp_pkg.sv
hw/udp_header_parse.sv
hw/udp_cksum.sv
hw/udp_verdict.sv
hw/udp_rx.sv
verif/tb_udp_rx.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_udp_rx
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
